//--- Bender.yml
package:
  name: scope_datapath

export_include_dirs:
  - src

sources:
  - files:
      - src/scope_pkg.sv
      - src/adc_frontend.sv
      - src/lin_calib.sv
      - src/trig_debounce.sv
      - src/acq_fsm.sv
      - src/scope_top.sv
  - target: test
    files:
      - verif/scope_assert.sv
      - verif/scope_tb.sv

//--- build.f
+incdir+src
src/scope_pkg.sv
src/adc_frontend.sv
src/lin_calib.sv
src/trig_debounce.sv
src/acq_fsm.sv
src/scope_top.sv
verif/scope_assert.sv
verif/scope_tb.sv

//--- src/acq_fsm.sv
// acquisition controller FSM
// arm, trigger select and capture sequencing
// sample counter against the latched capture length
// busy, valid and done status outputs

`timescale 1ns/100ps

`include "scope_consts.svh"

module acq_fsm import scope_pkg::*; (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // control
  input  acq_cmd_e                cmd_i,
  input  trg_src_e                trg_src_i,
  input  logic                    ext_pe_i,   // debounced rising edge
  input  logic                    ext_ne_i,   // debounced falling edge
  input  logic [`SCOPE_LEN_W-1:0] acq_len_i,  // samples per capture, 0 means 1
  // status
  output logic                    acq_vld_o,
  output logic                    acq_busy_o,
  output logic                    acq_done_o
);

  acq_state_e              state_q;
  logic [`SCOPE_LEN_W-1:0] cnt_q;    // samples captured so far
  logic [`SCOPE_LEN_W-1:0] len_q;    // length taken at trigger
  logic [`SCOPE_LEN_W-1:0] len_eff;
  logic                    trg_hit;
  logic                    last;     // final valid cycle
  logic                    done_q;

  assign len_eff = (acq_len_i == '0) ? {{(`SCOPE_LEN_W-1){1'b0}}, 1'b1} : acq_len_i;
  assign last    = (cnt_q == len_q - 1'b1);

  // trigger source select
  always_comb begin
    case (trg_src_i)
      TRG_SW:     trg_hit = (cmd_i == CMD_SW_TRIG);
      TRG_EXT_PE: trg_hit = ext_pe_i;
      TRG_EXT_NE: trg_hit = ext_ne_i;
      default:    trg_hit = 1'b0;  // unused encoding
    endcase
  end

  //////////////////////////////
  // state register
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      len_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (cmd_i == CMD_STOP) begin
        state_q <= ST_IDLE;  // abort, no done pulse
      end else begin
        case (state_q)
          ST_IDLE: begin
            if (cmd_i == CMD_ARM) state_q <= ST_ARMED;
          end
          ST_ARMED: begin
            if (trg_hit) begin
              state_q <= ST_CAPTURE;  // first sample next cycle
              cnt_q   <= '0;
              len_q   <= len_eff;
            end
          end
          ST_CAPTURE: begin
            cnt_q <= cnt_q + 1'b1;
            if (last) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
            end
          end
          default: state_q <= ST_IDLE;
        endcase
      end
    end
  end

  assign acq_vld_o  = (state_q == ST_CAPTURE);
  assign acq_busy_o = (state_q != ST_IDLE);
  assign acq_done_o = done_q;  // cycle after the last sample

endmodule : acq_fsm

//--- src/adc_frontend.sv
// ADC input register stage
// pin format to signed sample conversion
// digital loopback multiplexer in front of the register

`timescale 1ns/100ps

`include "scope_consts.svh"

module adc_frontend import scope_pkg::*; (
  input  logic                        adc_clk,
  input  logic                        top_rst,
  // ADC pins
  input  logic        [`SCOPE_DW-1:0] adc_dat_i,  // raw pin word
  // loopback
  input  logic                        loop_i,     // select calibrated DAC sample
  input  logic signed [`SCOPE_DW-1:0] dac_cal_i,
  // sample toward ADC calibration
  output logic signed [`SCOPE_DW-1:0] adc_raw_o
);

  //////////////////////////////
  // pin format conversion
  //////////////////////////////

  logic signed [`SCOPE_DW-1:0] pin_cnv;  // converted pin word
  logic signed [`SCOPE_DW-1:0] raw_q;

  // MSB stays, the rest comes inverted from the converter
  assign pin_cnv = {adc_dat_i[`SCOPE_DW-1], ~adc_dat_i[`SCOPE_DW-2:0]};

  //////////////////////////////
  // input register
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      raw_q <= '0;
    end else begin
      raw_q <= loop_i ? dac_cal_i : pin_cnv;  // loopback bypasses conversion
    end
  end

  assign adc_raw_o = raw_q;

endmodule : adc_frontend

//--- src/lin_calib.sv
// linear gain and offset calibration
// stage one registers the full signed product
// stage two scales, adds the offset and saturates
// two samples in flight, one new sample per cycle

`timescale 1ns/100ps

`include "scope_consts.svh"

module lin_calib import scope_pkg::*; (
  input  logic                        adc_clk,
  input  logic                        top_rst,
  input  logic signed [`SCOPE_DW-1:0] dat_i,
  input  logic signed [`SCOPE_MW-1:0] mul_i,  // 8192 is unity gain
  input  logic signed [`SCOPE_DW-1:0] sum_i,  // offset in sample units
  output logic signed [`SCOPE_DW-1:0] dat_o
);

  localparam int PW = `SCOPE_DW + `SCOPE_MW;    // full product width
  localparam int AW = PW - `SCOPE_FRAC + 1;     // scaled product plus carry bit
  localparam logic signed [AW-1:0] DMAX = (1 <<< (`SCOPE_DW-1)) - 1;
  localparam logic signed [AW-1:0] DMIN = -(1 <<< (`SCOPE_DW-1));

  logic signed [PW-1:0]        prod_q;   // stage one
  logic signed [PW-1:0]        prod_sh;  // product after fraction shift
  logic signed [AW-1:0]        acc;      // scaled product plus offset
  logic signed [`SCOPE_DW-1:0] sat;
  logic signed [`SCOPE_DW-1:0] dat_q;    // stage two

  assign prod_sh = prod_q >>> `SCOPE_FRAC;       // arithmetic, keeps sign
  assign acc     = AW'(prod_sh) + AW'(sum_i);

  // clamp to the signed sample range
  always_comb begin
    if (acc > DMAX)      sat = DMAX[`SCOPE_DW-1:0];
    else if (acc < DMIN) sat = DMIN[`SCOPE_DW-1:0];
    else                 sat = acc[`SCOPE_DW-1:0];
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
      dat_q  <= '0;
    end else begin
      prod_q <= dat_i * mul_i;  // 14x16 signed
      dat_q  <= sat;
    end
  end

  assign dat_o = dat_q;

endmodule : lin_calib

//--- src/scope_consts.svh
// shared width and length macros for the scope datapath
// sample, gain and fraction widths for the calibration stages
// trigger hold timer and capture counter widths
// default trigger hold and capture lengths

`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// sample path
`define SCOPE_DW      14        // ADC/DAC sample width
`define SCOPE_MW      16        // signed gain width
`define SCOPE_FRAC    13        // gain 8192 is unity

// control path
`define SCOPE_DEB_CW  20        // debounce timer width
`define SCOPE_LEN_W   16        // capture length width

// defaults
`define SCOPE_DEB_LEN_DEF  20'd62500   // 0.5 ms at 125 MHz
`define SCOPE_ACQ_LEN_DEF  16'd1024    // samples per capture

`endif

//--- src/scope_pkg.sv
// types for the scope acquisition controller
// controller states, command opcodes and trigger sources

package scope_pkg;

  // acquisition controller states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,  // waiting for arm
    ST_ARMED   = 2'd1,  // waiting for trigger
    ST_CAPTURE = 2'd2   // samples are valid
  } acq_state_e;

  // software commands, one per cycle
  typedef enum logic [1:0] {
    CMD_NONE    = 2'd0,
    CMD_ARM     = 2'd1,
    CMD_SW_TRIG = 2'd2,  // only acts with TRG_SW
    CMD_STOP    = 2'd3   // abort from any state
  } acq_cmd_e;

  // trigger source select
  typedef enum logic [1:0] {
    TRG_SW     = 2'd0,  // software trigger command
    TRG_EXT_PE = 2'd1,  // expansion pin rising edge
    TRG_EXT_NE = 2'd2   // expansion pin falling edge
  } trg_src_e;

endpackage : scope_pkg

//--- src/scope_top.sv
// single channel scope datapath top level
// ADC front end and calibration toward acquisition
// DAC calibration and output format register
// trigger debouncer and acquisition controller

`timescale 1ns/100ps

`include "scope_consts.svh"

module scope_top import scope_pkg::*; (
  input  logic                        adc_clk,
  input  logic                        top_rst,
  // sample streams
  input  logic        [`SCOPE_DW-1:0] adc_dat_i,  // ADC pins
  input  logic signed [`SCOPE_DW-1:0] dac_dat_i,  // generator sample
  input  logic                        loop_i,
  // calibration
  input  logic signed [`SCOPE_MW-1:0] adc_mul_i,
  input  logic signed [`SCOPE_DW-1:0] adc_sum_i,
  input  logic signed [`SCOPE_MW-1:0] dac_mul_i,
  input  logic signed [`SCOPE_DW-1:0] dac_sum_i,
  // trigger and control
  input  logic                        exp_trg_i,
  input  logic    [`SCOPE_DEB_CW-1:0] deb_len_i,
  input  trg_src_e                    trg_src_i,
  input  acq_cmd_e                    cmd_i,
  input  logic     [`SCOPE_LEN_W-1:0] acq_len_i,
  // acquisition
  output logic signed [`SCOPE_DW-1:0] acq_dat_o,
  output logic                        acq_vld_o,
  output logic                        acq_busy_o,
  output logic                        acq_done_o,
  // DAC pins
  output logic        [`SCOPE_DW-1:0] dac_dat_o
);

  logic signed [`SCOPE_DW-1:0] adc_raw;  // after input register
  logic signed [`SCOPE_DW-1:0] dac_cal;  // calibrated DAC sample
  logic        [`SCOPE_DW-1:0] dac_q;
  logic                        ext_pe;
  logic                        ext_ne;

  //////////////////////////////
  // ADC path
  //////////////////////////////

  adc_frontend u_frontend (.adc_clk(adc_clk), .top_rst(top_rst), .adc_dat_i(adc_dat_i),
                           .loop_i(loop_i), .dac_cal_i(dac_cal), .adc_raw_o(adc_raw));

  lin_calib u_adc_cal (.adc_clk(adc_clk), .top_rst(top_rst), .dat_i(adc_raw),
                       .mul_i(adc_mul_i), .sum_i(adc_sum_i), .dat_o(acq_dat_o));

  //////////////////////////////
  // DAC path
  //////////////////////////////

  lin_calib u_dac_cal (.adc_clk(adc_clk), .top_rst(top_rst), .dat_i(dac_dat_i),
                       .mul_i(dac_mul_i), .sum_i(dac_sum_i), .dat_o(dac_cal));

  // output register, signed to converter format
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) dac_q <= '0;
    else         dac_q <= {dac_cal[`SCOPE_DW-1], ~dac_cal[`SCOPE_DW-2:0]};
  end

  assign dac_dat_o = dac_q;

  //////////////////////////////
  // trigger and control
  //////////////////////////////

  trig_debounce #(.debounce_init(1'b0)) u_debounce (.adc_clk(adc_clk), .top_rst(top_rst),
    .trg_i(exp_trg_i), .deb_len_i(deb_len_i), .pe_o(ext_pe), .ne_o(ext_ne));

  acq_fsm u_acq (.adc_clk(adc_clk), .top_rst(top_rst), .cmd_i(cmd_i), .trg_src_i(trg_src_i),
                 .ext_pe_i(ext_pe), .ext_ne_i(ext_ne), .acq_len_i(acq_len_i),
                 .acq_vld_o(acq_vld_o), .acq_busy_o(acq_busy_o), .acq_done_o(acq_done_o));

endmodule : scope_top

//--- src/trig_debounce.sv
// trigger input debouncer
// two flop synchronizer on the expansion pin
// hold timer against the stable level
// single cycle rising and falling edge pulses

`timescale 1ns/100ps

`include "scope_consts.svh"

module trig_debounce import scope_pkg::*; #(
  parameter bit debounce_init = 1'b0  // stable level out of reset
)(
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  logic                     trg_i,      // asynchronous pin
  input  logic [`SCOPE_DEB_CW-1:0] deb_len_i,  // hold time in cycles
  output logic                     pe_o,       // rising edge accepted
  output logic                     ne_o        // falling edge accepted
);

  logic [1:0]               sync_q;     // synchronizer chain
  logic                     lvl_q;      // debounced level
  logic [`SCOPE_DEB_CW-1:0] cnt_q;      // cycles differing from lvl_q
  logic [`SCOPE_DEB_CW:0]   cnt_nxt;    // one extra bit, no wrap
  logic                     hold_done;  // last differing cycle reached
  logic                     pe_q;
  logic                     ne_q;

  assign cnt_nxt   = {1'b0, cnt_q} + 1'b1;
  assign hold_done = (sync_q[1] != lvl_q) && (cnt_nxt >= {1'b0, deb_len_i});

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sync_q <= {2{debounce_init}};  // no edge right after reset
      lvl_q  <= debounce_init;
      cnt_q  <= '0;
      pe_q   <= 1'b0;
      ne_q   <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], trg_i};
      pe_q   <= hold_done &  sync_q[1];
      ne_q   <= hold_done & ~sync_q[1];
      if (sync_q[1] == lvl_q) begin
        cnt_q <= '0;                              // glitch restarts timer
      end else if (hold_done) begin
        lvl_q <= sync_q[1];
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_nxt[`SCOPE_DEB_CW-1:0];
      end
    end
  end

  assign pe_o = pe_q;
  assign ne_o = ne_q;

endmodule : trig_debounce

//--- verif/scope_assert.sv
// concurrent checks on the acquisition controller
// busy through each capture and gone right after it
// one cycle done pulse, no valid straight after idle

`timescale 1ns/100ps

module scope_assert import scope_pkg::*; (
  input logic       adc_clk,
  input logic       top_rst,
  input acq_state_e state_i,
  input logic       vld_i,
  input logic       busy_i,
  input logic       done_i
);

  int fail_cnt = 0;  // failed assertions so far

  // a capture ends straight in idle, never back in armed
  vld_busy: assert property (@(posedge adc_clk) disable iff (top_rst)
    vld_i |-> busy_i ##1 (vld_i || !busy_i))
    else begin
      $error("acq_busy_o did not track acq_vld_o through the capture");
      fail_cnt++;
    end

  done_once: assert property (@(posedge adc_clk) disable iff (top_rst) done_i |=> !done_i)
    else begin
      $error("acq_done_o lasted more than one cycle");
      fail_cnt++;
    end

  // capture is entered only through the armed state
  idle_quiet: assert property (@(posedge adc_clk) disable iff (top_rst)
    (state_i == ST_IDLE) |=> !vld_i)
    else begin
      $error("acq_vld_o high right after ST_IDLE");
      fail_cnt++;
    end

endmodule : scope_assert

//--- verif/scope_tb.sv
// testbench for the single channel scope datapath
// clock, reset and random sample stimulus every cycle
// reference model of pin format and calibration, checked every cycle
// capture control and trigger debounce sequences, watchdog

`timescale 1ns/100ps

`include "scope_consts.svh"

module scope_tb import scope_pkg::*; ();

  localparam int CLK_PER  = 4;
  localparam int RST_CYC  = 10;
  localparam int STIM_CYC = 800;  // all phases together
  localparam int MARGIN   = 200;

  logic                        adc_clk, top_rst, loop_i, exp_trg_i;
  logic        [`SCOPE_DW-1:0] adc_dat_i;
  logic signed [`SCOPE_DW-1:0] dac_dat_i, adc_sum_i, dac_sum_i;
  logic signed [`SCOPE_MW-1:0] adc_mul_i, dac_mul_i;
  logic    [`SCOPE_DEB_CW-1:0] deb_len_i;
  logic     [`SCOPE_LEN_W-1:0] acq_len_i;
  trg_src_e                    trg_src_i;
  acq_cmd_e                    cmd_i;
  logic signed [`SCOPE_DW-1:0] acq_dat_o;
  logic                        acq_vld_o, acq_busy_o, acq_done_o;
  logic        [`SCOPE_DW-1:0] dac_dat_o;

  int seed = 32'hf88d;
  int data_err, ctrl_err, vld_cnt, done_cnt, sat_hi, sat_lo, hn;
  int v0, d0, exp_acq;
  logic [`SCOPE_DW-1:0] exp_pin;
  // 16 deep input history ring indexed by negedge count
  logic [`SCOPE_DW-1:0] h_adc [16];
  int h_dac [16], h_amul [16], h_asum [16], h_dmul [16], h_dsum [16];
  bit h_loop [16];

  scope_top DUT (.adc_clk(adc_clk), .top_rst(top_rst), .adc_dat_i(adc_dat_i),
    .dac_dat_i(dac_dat_i), .loop_i(loop_i), .adc_mul_i(adc_mul_i), .adc_sum_i(adc_sum_i),
    .dac_mul_i(dac_mul_i), .dac_sum_i(dac_sum_i), .exp_trg_i(exp_trg_i), .deb_len_i(deb_len_i),
    .trg_src_i(trg_src_i), .cmd_i(cmd_i), .acq_len_i(acq_len_i), .acq_dat_o(acq_dat_o),
    .acq_vld_o(acq_vld_o), .acq_busy_o(acq_busy_o), .acq_done_o(acq_done_o),
    .dac_dat_o(dac_dat_o));

  bind acq_fsm scope_assert u_assert (.adc_clk(adc_clk), .top_rst(top_rst), .state_i(state_q),
    .vld_i(acq_vld_o), .busy_i(acq_busy_o), .done_i(acq_done_o));

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PER/2) adc_clk = ~adc_clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic int pin_to_sample(logic [`SCOPE_DW-1:0] pin);
    logic signed [`SCOPE_DW-1:0] s;
    s = pin ^ 14'h1fff;  // MSB kept and low bits inverted
    return int'(s);
  endfunction

  function automatic logic [`SCOPE_DW-1:0] sample_to_pin(int s);
    return s[`SCOPE_DW-1:0] ^ 14'h1fff;
  endfunction

  // scale with unity at 8192 then add offset and clamp
  function automatic int calib_ref(int d, int m, int s);
    int a;
    a = ((d * m) >>> `SCOPE_FRAC) + s;
    if (a > 8191) return 8191;
    if (a < -8192) return -8192;
    return a;
  endfunction

  // calibrated DAC sample seen at negedge p
  // inputs recorded at negedge k reach the registers at the following posedge
  function automatic int dac_cal_at(int p);
    return calib_ref(h_dac[(p-2) & 15], h_dmul[(p-2) & 15], h_dsum[(p-1) & 15]);
  endfunction

  function automatic int raw_at(int m);
    return h_loop[(m-1) & 15] ? dac_cal_at(m-1) : pin_to_sample(h_adc[(m-1) & 15]);
  endfunction

  function automatic int acq_at(int n);
    return calib_ref(raw_at(n-2), h_amul[(n-2) & 15], h_asum[(n-1) & 15]);
  endfunction

  // outputs compared mid cycle where they are stable
  always @(negedge adc_clk) begin
    if (!top_rst) begin
      h_adc[hn & 15]  = adc_dat_i;
      h_dac[hn & 15]  = dac_dat_i;
      h_loop[hn & 15] = loop_i;
      h_amul[hn & 15] = adc_mul_i;
      h_asum[hn & 15] = adc_sum_i;
      h_dmul[hn & 15] = dac_mul_i;
      h_dsum[hn & 15] = dac_sum_i;
      if (hn >= 6) begin  // history filled
        exp_acq = acq_at(hn);
        exp_pin = sample_to_pin(dac_cal_at(hn-1));
        assert (acq_dat_o == exp_acq) else begin
          $display("ERROR %0t: acq_dat_o %0d, expected %0d", $time, acq_dat_o, exp_acq);
          data_err++;
        end
        assert (dac_dat_o == exp_pin) else begin
          $display("ERROR %0t: dac_dat_o %h, expected %h", $time, dac_dat_o, exp_pin);
          data_err++;
        end
        if (acq_dat_o == 8191) sat_hi++;
        if (acq_dat_o == -8192) sat_lo++;
      end
      vld_cnt += acq_vld_o;
      done_cnt += acq_done_o;
      hn++;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic tick();
    @(posedge adc_clk);
    #1;
    adc_dat_i = `SCOPE_DW'($random(seed));
    dac_dat_i = `SCOPE_DW'($random(seed));
  endtask

  task automatic cycles(int k);
    repeat (k) tick();
  endtask

  task automatic issue(acq_cmd_e c);
    tick();
    cmd_i = c;
    tick();  // command lasts one edge
    cmd_i = CMD_NONE;
  endtask

  task automatic load_calib(int am, int as, int dm, int ds);
    adc_mul_i = `SCOPE_MW'(am);
    adc_sum_i = `SCOPE_DW'(as);
    dac_mul_i = `SCOPE_MW'(dm);
    dac_sum_i = `SCOPE_DW'(ds);
  endtask

  task automatic wait_done(int limit);
    int i;
    i = 0;
    while (done_cnt == d0 && i < limit) begin
      tick();
      i++;
    end
    assert (done_cnt != d0) else begin
      $display("capture did not finish, no acq_done_o within %0d cycles", limit);
      ctrl_err++;
    end
  endtask

  task automatic expect_counts(int vld_exp, int done_exp, string what);
    assert (vld_cnt - v0 == vld_exp && done_cnt - d0 == done_exp) else begin
      $display("ERROR %0t: %s gave %0d valid and %0d done, expected %0d and %0d", $time,
               what, vld_cnt - v0, done_cnt - d0, vld_exp, done_exp);
      ctrl_err++;
    end
  endtask

  task automatic capture_sw(int len);
    int exp_len;
    exp_len = (len == 0) ? 1 : len;  // zero length acts as one
    acq_len_i = `SCOPE_LEN_W'(len);
    v0 = vld_cnt;
    d0 = done_cnt;
    issue(CMD_ARM);
    // armed and waiting for the trigger
    assert (acq_busy_o && !acq_vld_o) else begin
      $display("ERROR %0t: armed with busy %b and valid %b, expected 1 and 0", $time,
               acq_busy_o, acq_vld_o);
      ctrl_err++;
    end
    issue(CMD_SW_TRIG);
    wait_done(exp_len + 10);
    cycles(3);
    expect_counts(exp_len, 1, "software capture");
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    top_rst = 1'b1;
    adc_dat_i = '0;
    dac_dat_i = '0;
    loop_i = 1'b0;
    exp_trg_i = 1'b0;
    deb_len_i = 20'd8;
    acq_len_i = 16'd8;
    trg_src_i = TRG_SW;
    cmd_i = CMD_NONE;
    load_calib(8192, 0, 8192, 0);
    repeat (RST_CYC) @(posedge adc_clk);
    #1 top_rst = 1'b0;
    // random gain and offset on both paths
    repeat (4) begin
      load_calib(8192 + $random(seed) % 4096, $random(seed) % 512,
                 8192 + $random(seed) % 4096, $random(seed) % 512);
      cycles(50);
    end
    // clamp at both rails
    load_calib(32767, 4000, 32767, -4000);
    cycles(40);
    load_calib(32767, -4000, -32768, 4000);
    cycles(40);
    load_calib(-32768, 0, 32767, 0);
    cycles(40);
    // loopback through both calibrations
    loop_i = 1'b1;
    repeat (2) begin
      load_calib(8192 + $random(seed) % 4096, $random(seed) % 512,
                 8192 + $random(seed) % 4096, $random(seed) % 512);
      cycles(60);
    end
    loop_i = 1'b0;
    cycles(10);
    // capture control
    capture_sw(5);
    capture_sw(0);
    capture_sw(17);
    acq_len_i = 16'd40;
    v0 = vld_cnt;
    d0 = done_cnt;
    issue(CMD_ARM);
    issue(CMD_SW_TRIG);
    cycles(5);
    issue(CMD_STOP);
    cycles(50);
    assert (done_cnt == d0 && vld_cnt - v0 > 0 && vld_cnt - v0 < 40 &&
            !acq_vld_o && !acq_busy_o) else begin
      $display("CMD_STOP did not abort a running capture cleanly");
      ctrl_err++;
    end
    // debounced rising edge trigger
    trg_src_i = TRG_EXT_PE;
    acq_len_i = 16'd4;
    v0 = vld_cnt;
    d0 = done_cnt;
    issue(CMD_ARM);
    repeat (3) begin
      exp_trg_i = 1'b1;
      cycles(4);  // shorter than the hold time
      exp_trg_i = 1'b0;
      cycles(10);
    end
    expect_counts(0, 0, "short trigger pulses");
    exp_trg_i = 1'b1;
    wait_done(40);
    cycles(20);
    expect_counts(4, 1, "held rising level");
    v0 = vld_cnt;
    d0 = done_cnt;
    issue(CMD_ARM);
    exp_trg_i = 1'b0;
    cycles(30);
    expect_counts(0, 0, "falling edge under TRG_EXT_PE");
    issue(CMD_STOP);
    cycles(5);
    assert (sat_hi > 0 && sat_lo > 0) else begin
      $display("acq_dat_o never reached both rails (high %0d, low %0d)", sat_hi, sat_lo);
      data_err++;
    end
    $display("errors: data %0d, control %0d, assertion %0d", data_err, ctrl_err,
             DUT.u_acq.u_assert.fail_cnt);
    if (data_err + ctrl_err + DUT.u_acq.u_assert.fail_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog
  initial begin
    #((RST_CYC + STIM_CYC + MARGIN) * CLK_PER);
    $display("watchdog expired, the run did not end within %0d cycles", STIM_CYC + MARGIN);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : scope_tb
